/* bench/cart_loader_tb.sv */
// Cartridge loader testbench
// Replays download records from the test data file, acknowledges ROM
// writes after a random delay and checks each result against a model

`timescale 1ns/10ps

`include "loader_config.svh"

module cart_loader_tb;

	localparam int CLK_NS       = 4;
	localparam int RESET_CYCLES = 10;
	localparam int HDR_BIT      = $clog2(`HDR_OFFSET);

	logic                     clk_sys;
	logic                     RESET;
	logic                     ioctl_download;
	ioctl_pkg::ioctl_index_t  ioctl_index;
	ioctl_pkg::ioctl_addr_t   ioctl_addr;
	ioctl_pkg::ioctl_byte_t   ioctl_dout;
	logic                     ioctl_wr;
	logic                     rom_ack = 1'b0;
	logic                     ioctl_wait;
	logic                     rom_req;
	ioctl_pkg::rom_addr_t     rom_addr;
	ioctl_pkg::ioctl_byte_t   rom_data;
	cart_pkg::cart_mask_t     cart_mask;
	cart_pkg::cart_mask_t     cart_mask_hdr;
	logic                     cart_hdr;
	logic                     is_gg;
	logic                     is_arcade;
	ioctl_pkg::ioctl_byte_t   sysmode;
	cart_pkg::dip_bank_t      dip;
	cart_pkg::cheat_code_t    cheat_code;
	logic                     cheat_strobe;

	// Reference model state
	ioctl_pkg::ioctl_index_t  cur_index    = '0;
	logic                     cart_class   = 1'b0;
	ioctl_pkg::rom_addr_t     exp_rom_addr = '0;
	cart_pkg::cart_mask_t     exp_mask     = '0;
	cart_pkg::cart_mask_t     exp_mask_hdr = '0;
	ioctl_pkg::ioctl_addr_t   last_addr    = '0;
	logic                     exp_hdr      = 1'b0;
	logic                     exp_gg       = 1'b0;
	logic                     exp_arcade   = 1'b0;
	logic                     ack_busy     = 1'b0;
	logic [2:0]               ack_delay    = '0;
	longint                   limit_ns     = 0;

	clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
		.clk_sys (clk_sys),
		.RESET   (RESET)
	);

	cart_loader cart_loader_i (.*);

	// ====================================================================
	// ROM memory model and watchdog
	// ====================================================================
	// Acknowledge 0 to 7 cycles after a new request
	always @(posedge clk_sys) begin
		if (RESET) begin
			rom_ack  <= 1'b0;
			ack_busy <= 1'b0;
		end else if (!ack_busy && (rom_req != rom_ack)) begin
			ack_busy  <= 1'b1;
			ack_delay <= 3'($urandom % 8);
		end else if (ack_busy) begin
			if (ack_delay == 3'd0) begin
				rom_ack  <= rom_req;
				ack_busy <= 1'b0;
			end else
				ack_delay <= ack_delay - 3'd1;
		end
	end

	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		abort_run("Watchdog expired before all test records were run");
	end

	// ====================================================================
	// Compare tasks
	// ====================================================================
	task automatic abort_run(string why);
		$display("ERRORS FOUND");
		$fatal(1, "%s", why);
	endtask

	task automatic addr_compare(string name, ioctl_pkg::rom_addr_t got,
		ioctl_pkg::rom_addr_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			abort_run("Output differs from the model");
		end
	endtask

	task automatic byte_compare(string name, ioctl_pkg::ioctl_byte_t got,
		ioctl_pkg::ioctl_byte_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			abort_run("Output differs from the model");
		end
	endtask

	task automatic mask_compare(string name, cart_pkg::cart_mask_t got,
		cart_pkg::cart_mask_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			abort_run("Output differs from the model");
		end
	endtask

	task automatic dip_compare(string name, cart_pkg::dip_bank_t got,
		cart_pkg::dip_bank_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			abort_run("Output differs from the model");
		end
	endtask

	task automatic cheat_compare(string name, cart_pkg::cheat_code_t got,
		cart_pkg::cheat_code_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			abort_run("Output differs from the model");
		end
	endtask

	task automatic flag_compare(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			abort_run("Output differs from the model");
		end
	endtask

	// ====================================================================
	// Host bus driver
	// ====================================================================
	task automatic open_download(ioctl_pkg::ioctl_index_t idx);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= idx;
		cur_index = idx;
		cart_class = (idx != `IDX_SYSMODE) && (idx != `IDX_DIP) && (idx != `IDX_CHEAT);
		if (cart_class)
			exp_rom_addr = '0;
		@(negedge clk_sys);
	endtask

	task automatic close_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		// Header flag comes from the last address of the image
		if (cart_class)
			exp_hdr = last_addr[HDR_BIT];
		@(posedge clk_sys);
		@(negedge clk_sys);
		flag_compare("cart_hdr", cart_hdr, exp_hdr);
		flag_compare("is_gg", is_gg, exp_gg);
		flag_compare("is_arcade", is_arcade, exp_arcade);
	endtask

	task automatic write_byte(ioctl_pkg::ioctl_addr_t addr, ioctl_pkg::ioctl_byte_t data);
		logic req_before;
		logic [3:0] sel;
		req_before = rom_req;
		sel = addr[3:0];
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(negedge clk_sys);
		if (cart_class) begin
			if (addr == 0)
				exp_mask = '0;
			else
				exp_mask = exp_mask | cart_pkg::cart_mask_t'(addr);
			if (addr == `HDR_OFFSET)
				exp_mask_hdr = '0;
			else
				exp_mask_hdr = exp_mask_hdr | cart_pkg::cart_mask_t'(addr - `HDR_OFFSET);
			exp_gg = (cur_index[4:0] == 5'(`IDX_CART_GG));
			if ((cur_index == `IDX_CART_SMS) || (cur_index == `IDX_CART_GG))
				exp_arcade = 1'b0;
			last_addr = addr;
			flag_compare("ioctl_wait", ioctl_wait, 1'b1);
			flag_compare("rom_req", rom_req, ~req_before);
			byte_compare("rom_data", rom_data, data);
			addr_compare("rom_addr", rom_addr, exp_rom_addr);
			mask_compare("cart_mask", cart_mask, exp_mask);
			mask_compare("cart_mask_hdr", cart_mask_hdr, exp_mask_hdr);
			// Host stays held off until the memory has taken the byte
			while (ioctl_wait)
				@(negedge clk_sys);
			flag_compare("rom_ack", rom_ack, rom_req);
			exp_rom_addr++;
			addr_compare("rom_addr", rom_addr, exp_rom_addr);
		end else begin
			if (cur_index == `IDX_SYSMODE)
				exp_arcade = 1'b1;
			flag_compare("ioctl_wait", ioctl_wait, 1'b0);
			flag_compare("cheat_strobe", cheat_strobe,
				(sel == 4'hf) && (cur_index == `IDX_CHEAT));
		end
	endtask

	// One cheat record with each field sent low byte first
	task automatic send_cheat(logic [31:0] flags, logic [31:0] addr,
		logic [31:0] cmp, logic [31:0] rep);
		cart_pkg::cheat_code_t want;
		logic [31:0] word;
		want.flags   = flags;
		want.address = addr;
		want.compare = cmp;
		want.replace = rep;
		for (int i = 0; i < `CHEAT_BYTES; i++) begin
			word = (i < 4) ? flags : (i < 8) ? addr : (i < 12) ? cmp : rep;
			write_byte(ioctl_pkg::ioctl_addr_t'(i), word[(i % 4) * 8 +: 8]);
		end
		cheat_compare("cheat_code", cheat_code, want);
		@(negedge clk_sys);
		flag_compare("cheat_strobe", cheat_strobe, 1'b0);
	endtask

	// ====================================================================
	// Test sequence
	// ====================================================================
	initial begin
		int                   fd;
		string                line;
		string                recs[$];
		logic [31:0]          v0;
		logic [31:0]          v1;
		logic [31:0]          v2;
		logic [31:0]          v3;
		cart_pkg::dip_bank_t  want_dip;
		void'($urandom(32'hee6b_8dbd));
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		fd = $fopen("bench/cart_loader_testdata.txt", "r");
		if (fd == 0)
			abort_run("Cannot open the test data file");
		while ($fgets(line, fd) != 0) begin
			if ((line.len() > 1) && (line.getc(0) != "#"))
				recs.push_back(line);
		end
		$fclose(fd);
		limit_ns = (longint'(recs.size()) * 16 + RESET_CYCLES) * CLK_NS;

		@(negedge clk_sys);
		while (RESET)
			@(negedge clk_sys);
		flag_compare("ioctl_wait", ioctl_wait, 1'b0);
		flag_compare("rom_req", rom_req, 1'b0);
		flag_compare("cheat_strobe", cheat_strobe, 1'b0);
		addr_compare("rom_addr", rom_addr, '0);

		foreach (recs[i]) begin
			line = recs[i];
			void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", v0, v1, v2, v3));
			case (line.getc(0))
				"B": open_download(v0[7:0]);
				"W": write_byte(ioctl_pkg::ioctl_addr_t'(v0), v1[7:0]);
				"E": close_download();
				"S": byte_compare("sysmode", sysmode, v0[7:0]);
				"P": begin
					want_dip[0] = v0[7:0];
					want_dip[1] = v1[7:0];
					want_dip[2] = v2[7:0];
					dip_compare("dip", dip, want_dip);
				end
				"C": send_cheat(v0, v1, v2, v3);
				default: abort_run("Unknown record type in the test data");
			endcase
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* bench/cart_loader_testdata.txt */
# One record per line, letter first, then hex fields
# B index | W addr data | E | S sysmode | P dip0 dip1 dip2 | C flags address compare replace
B 02
W 0 3c
W 1 a5
W 2 5a
W 200 11
W 201 22
W 3ff 7e
E
B 04
W 0 96
E
S 96
B fe
W 0 12
W 1 34
W 2 56
E
P 12 34 56
B 01
W 0 f0
W 1 0f
W 6 c3
E
B ff
C 00000001 00c0ffee 0000a5a5 12345678
E

/* bench/clock_gen.sv */
// Testbench clock and reset
// Free-running clock, reset held high for the first rising edges

`timescale 1ns/10ps

module clock_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_sys,
	output logic RESET
);

	initial begin
		clk_sys = 1'b0;
		forever
			#(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		RESET = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge clk_sys);
		RESET <= 1'b0;
	end

endmodule

/* logic/cart_loader.sv */
// Cartridge loader top level
// Puts the host download bus on an interface and feeds the ROM writer,
// the cartridge profile and the cheat loader

`timescale 1ns/10ps

`include "loader_config.svh"

module cart_loader (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  logic                     ioctl_download,
	input  ioctl_pkg::ioctl_index_t  ioctl_index,
	input  ioctl_pkg::ioctl_addr_t   ioctl_addr,
	input  ioctl_pkg::ioctl_byte_t   ioctl_dout,
	input  logic                     ioctl_wr,
	input  logic                     rom_ack,
	output logic                     ioctl_wait,
	output logic                     rom_req,
	output ioctl_pkg::rom_addr_t     rom_addr,
	output ioctl_pkg::ioctl_byte_t   rom_data,
	output cart_pkg::cart_mask_t     cart_mask,
	output cart_pkg::cart_mask_t     cart_mask_hdr,
	output logic                     cart_hdr,
	output logic                     is_gg,
	output logic                     is_arcade,
	output ioctl_pkg::ioctl_byte_t   sysmode,
	output cart_pkg::dip_bank_t      dip,
	output cart_pkg::cheat_code_t    cheat_code,
	output logic                     cheat_strobe
);

	ioctl_if bus ();

	// Host side of the bus
	assign bus.download = ioctl_download;
	assign bus.index    = ioctl_index;
	assign bus.addr     = ioctl_addr;
	assign bus.dout     = ioctl_dout;
	assign bus.wr       = ioctl_wr;

	rom_writer rom_writer_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.bus        (bus.sink),
		.rom_ack    (rom_ack),
		.ioctl_wait (ioctl_wait),
		.rom_req    (rom_req),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data)
	);

	cart_profile cart_profile_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.bus           (bus.sink),
		.cart_mask     (cart_mask),
		.cart_mask_hdr (cart_mask_hdr),
		.cart_hdr      (cart_hdr),
		.is_gg         (is_gg),
		.is_arcade     (is_arcade),
		.sysmode       (sysmode),
		.dip           (dip)
	);

	cheat_loader cheat_loader_i (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.bus          (bus.sink),
		.cheat_code   (cheat_code),
		.cheat_strobe (cheat_strobe)
	);

endmodule

/* logic/cart_pkg.sv */
// Cartridge profile and cheat record types
// Address masks, the DIP bank and the assembled cheat code

`include "loader_config.svh"

package cart_pkg;

	// Cartridge address mask
	typedef logic [`CART_MASK_W-1:0] cart_mask_t;

	// DIP switch byte n comes from download address n
	typedef logic [`DIP_COUNT-1:0][7:0] dip_bank_t;

	// One cheat record with flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

/* logic/cart_profile.sv */
// Cartridge profile
// Collects address masks, the header flag and the system flags from the
// cartridge stream, and holds the system-mode and DIP switch bytes

`timescale 1ns/10ps

`include "loader_config.svh"

module cart_profile (
	input  logic                    clk_sys,
	input  logic                    RESET,
	ioctl_if.sink                   bus,
	output cart_pkg::cart_mask_t    cart_mask,
	output cart_pkg::cart_mask_t    cart_mask_hdr,
	output logic                    cart_hdr,
	output logic                    is_gg,
	output logic                    is_arcade,
	output ioctl_pkg::ioctl_byte_t  sysmode,
	output cart_pkg::dip_bank_t     dip
);

	// Address bit that is set by an image with a header
	localparam int HDR_BIT = $clog2(`HDR_OFFSET);
	localparam int DIP_SEL_W = $clog2(`DIP_COUNT);

	logic                  cart_dl;
	logic                  cart_dl_d;
	logic                  cart_wr;
	logic                  sys_wr;
	logic                  dip_wr;
	cart_pkg::cart_mask_t  addr_low;
	logic [4:0]            idx_low;

	assign cart_dl = bus.download &&
		(bus.index != ioctl_pkg::ioctl_index_t'(`IDX_SYSMODE)) &&
		(bus.index != ioctl_pkg::ioctl_index_t'(`IDX_DIP)) &&
		(bus.index != ioctl_pkg::ioctl_index_t'(`IDX_CHEAT));

	assign cart_wr  = bus.wr && cart_dl;
	assign sys_wr   = bus.wr && (bus.index == ioctl_pkg::ioctl_index_t'(`IDX_SYSMODE));
	assign dip_wr   = bus.wr && (bus.index == ioctl_pkg::ioctl_index_t'(`IDX_DIP));
	assign addr_low = bus.addr[`CART_MASK_W-1:0];
	assign idx_low  = bus.index[4:0];

	// ====================================================================
	// Masks and system flags
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_d     <= 1'b0;
			cart_mask     <= '0;
			cart_mask_hdr <= '0;
			cart_hdr      <= 1'b0;
			is_gg         <= 1'b0;
			is_arcade     <= 1'b0;
		end else begin
			cart_dl_d <= cart_dl;
			if (cart_wr) begin
				// First byte of an image restarts the mask
				if (bus.addr == '0)
					cart_mask <= '0;
				else
					cart_mask <= cart_mask | addr_low;
				// Same again from behind the header
				if (bus.addr == ioctl_pkg::ioctl_addr_t'(`HDR_OFFSET))
					cart_mask_hdr <= '0;
				else
					cart_mask_hdr <= cart_mask_hdr |
						(addr_low - cart_pkg::cart_mask_t'(`HDR_OFFSET));
				is_gg <= (idx_low == 5'(`IDX_CART_GG));
				if ((bus.index == ioctl_pkg::ioctl_index_t'(`IDX_CART_SMS)) ||
					(bus.index == ioctl_pkg::ioctl_index_t'(`IDX_CART_GG)))
					is_arcade <= 1'b0;
			end
			// Last address tells whether the image had a header
			if (cart_dl_d && !cart_dl)
				cart_hdr <= bus.addr[HDR_BIT];
			if (sys_wr)
				is_arcade <= 1'b1;
		end
	end

	// Settings bytes
	always_ff @(posedge clk_sys) begin
		if (sys_wr && (bus.addr == '0))
			sysmode <= bus.dout;
		if (dip_wr && (bus.addr < ioctl_pkg::ioctl_addr_t'(`DIP_COUNT)))
			dip[bus.addr[DIP_SEL_W-1:0]] <= bus.dout;
	end

endmodule

/* logic/cheat_loader.sv */
// Cheat loader
// Assembles 16-byte cheat records into one code word and strobes it out

`timescale 1ns/10ps

`include "loader_config.svh"

module cheat_loader (
	input  logic                   clk_sys,
	input  logic                   RESET,
	ioctl_if.sink                  bus,
	output cart_pkg::cheat_code_t  cheat_code,
	output logic                   cheat_strobe
);

	localparam int SEL_W = $clog2(`CHEAT_BYTES);

	logic              code_wr;
	logic [SEL_W-1:0]  byte_sel;
	logic [6:0]        bit_pos;

	assign code_wr  = bus.wr && bus.download &&
		(bus.index == ioctl_pkg::ioctl_index_t'(`IDX_CHEAT));
	assign byte_sel = bus.addr[SEL_W-1:0];

	// Field 0 sits in the top word with each field low byte first
	assign bit_pos = {~byte_sel[3:2], byte_sel[1:0], 3'b000};

	always_ff @(posedge clk_sys) begin
		if (code_wr)
			cheat_code[bit_pos +: 8] <= bus.dout;
	end

	// Last byte of the record completes the code
	always_ff @(posedge clk_sys) begin
		if (RESET)
			cheat_strobe <= 1'b0;
		else
			cheat_strobe <= code_wr && (byte_sel == SEL_W'(`CHEAT_BYTES - 1));
	end

endmodule

/* logic/ioctl_if.sv */
// Host download bus
// Carries the download flag, index, address, data and write strobe

`timescale 1ns/10ps

interface ioctl_if;

	logic                     download;
	ioctl_pkg::ioctl_index_t  index;
	ioctl_pkg::ioctl_addr_t   addr;
	ioctl_pkg::ioctl_byte_t   dout;
	logic                     wr;

	// Host side drives everything
	modport host (output download, index, addr, dout, wr);

	// Receiving units only look
	modport sink (input download, index, addr, dout, wr);

endinterface

/* logic/ioctl_pkg.sv */
// Host download bus types
// Data byte, download index and the host and ROM address types

`include "loader_config.svh"

package ioctl_pkg;

	// One byte of download payload
	typedef logic [7:0] ioctl_byte_t;

	// Selects what the host is sending
	typedef logic [7:0] ioctl_index_t;

	// Byte address within the download
	typedef logic [`IOCTL_ADDR_W-1:0] ioctl_addr_t;

	// Write address towards ROM memory
	typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;

endpackage

/* logic/loader_config.svh */
// Cartridge loader configuration
// Download index codes, bus widths and record sizes shared by the design

`ifndef LOADER_CONFIG_SVH
`define LOADER_CONFIG_SVH

// Download index codes
`define IDX_CART_SMS  1
`define IDX_CART_GG   2
`define IDX_SYSMODE   4
`define IDX_DIP       254
`define IDX_CHEAT     255

// Bus and mask widths
`define IOCTL_ADDR_W  25
`define ROM_ADDR_W    24
`define CART_MASK_W   22

// Image header and record sizes
`define HDR_OFFSET    512
`define CHEAT_BYTES   16
`define DIP_COUNT     3

`endif

/* logic/rom_writer.sv */
// ROM writer
// Forwards cartridge bytes to ROM memory with a toggle request and
// acknowledge, and holds the host off while a byte is in flight

`timescale 1ns/10ps

`include "loader_config.svh"

module rom_writer (
	input  logic                    clk_sys,
	input  logic                    RESET,
	ioctl_if.sink                   bus,
	input  logic                    rom_ack,
	output logic                    ioctl_wait,
	output logic                    rom_req,
	output ioctl_pkg::rom_addr_t    rom_addr,
	output ioctl_pkg::ioctl_byte_t  rom_data
);

	logic cart_dl;
	logic cart_dl_d;
	logic cart_start;

	// Everything that is not a settings or cheat download is cartridge data
	assign cart_dl = bus.download &&
		(bus.index != ioctl_pkg::ioctl_index_t'(`IDX_SYSMODE)) &&
		(bus.index != ioctl_pkg::ioctl_index_t'(`IDX_DIP)) &&
		(bus.index != ioctl_pkg::ioctl_index_t'(`IDX_CHEAT));

	assign cart_start = cart_dl && !cart_dl_d;

	// ====================================================================
	// Request toggle and host wait
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_d  <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_req    <= 1'b0;
			rom_addr   <= '0;
		end else begin
			cart_dl_d <= cart_dl;
			if (cart_start)
				rom_addr <= '0;
			if (bus.wr && cart_dl) begin
				ioctl_wait <= 1'b1;
				rom_req    <= ~rom_req;
			end else if (ioctl_wait && (rom_req == rom_ack)) begin
				// Memory has taken the byte
				ioctl_wait <= 1'b0;
				if (!cart_start)
					rom_addr <= rom_addr + ioctl_pkg::rom_addr_t'(1);
			end
		end
	end

	// Byte held for the memory until the next write
	always_ff @(posedge clk_sys) begin
		if (bus.wr && cart_dl)
			rom_data <= bus.dout;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compiles and runs the cart_loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sim.f --top-module cart_loader_tb -o cart_loader_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/cart_loader_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

/* sim.f */
+incdir+logic
logic/ioctl_pkg.sv
logic/cart_pkg.sv
logic/ioctl_if.sv
logic/rom_writer.sv
logic/cart_profile.sv
logic/cheat_loader.sv
logic/cart_loader.sv
bench/clock_gen.sv
bench/cart_loader_tb.sv
